// ==== include/quirk_ids.svh ====
// Product codes of games that need a compatibility quirk.
// Included inside quirk_match after the cart_pkg import.
// A "?" in a code matches any character.

`ifndef QUIRK_IDS_SVH
`define QUIRK_IDS_SVH

localparam quirk_s Q_SRAM   = '{sram: 1'b1, default: 1'b0};
localparam quirk_s Q_EEPROM = '{eeprom: 1'b1, default: 1'b0};
localparam quirk_s Q_FIFO   = '{fifo: 1'b1, default: 1'b0};
localparam quirk_s Q_NORAM  = '{noram: 1'b1, default: 1'b0};
localparam quirk_s Q_PIER   = '{pier: 1'b1, default: 1'b0};
localparam quirk_s Q_SVP    = '{svp: 1'b1, default: 1'b0};
localparam quirk_s Q_FMBUSY = '{fmbusy: 1'b1, default: 1'b0};
localparam quirk_s Q_SCHAN  = '{schan: 1'b1, default: 1'b0};

typedef struct packed {
	logic [63:0] code;
	quirk_s      flag;
} quirk_id_s;

localparam int QUIRK_ID_COUNT = 24;

localparam quirk_id_s QUIRK_IDS [QUIRK_ID_COUNT] = '{
	// Battery RAM mapped in odd bytes
	'{"T-081276", Q_SRAM},   '{"T-81406 ", Q_SRAM},   '{"T-081586", Q_SRAM},
	'{"T-81576 ", Q_SRAM},   '{"T-81476 ", Q_SRAM},
	// Serial EEPROM saves
	'{"MK-1215 ", Q_EEPROM}, '{"G-4060  ", Q_EEPROM}, '{"00001211", Q_EEPROM},
	'{"MK-1228 ", Q_EEPROM}, '{"G-5538  ", Q_EEPROM}, '{"00004076", Q_EEPROM},
	'{"T-12046 ", Q_EEPROM}, '{"T-12053 ", Q_EEPROM}, '{"G-4524  ", Q_EEPROM},
	// Fake RAM check, fast VDP FIFO
	'{"T-113016", Q_NORAM},  '{"T-89016 ", Q_FIFO},
	'{"T-574023", Q_PIER},   '{"T-574013", Q_PIER},
	// DSP cartridge
	'{"MK-1229 ", Q_SVP},    '{"G-7001  ", Q_SVP},
	// Polls the FM busy flag
	'{"T-35036 ", Q_FMBUSY}, '{"T-25073 ", Q_FMBUSY}, '{"MK-1137-", Q_FMBUSY},
	'{"T-68???-", Q_SCHAN}
};

`endif

// ==== source/cart_pkg.sv ====
// Types and constants for the cartridge download path.
// Covers the host download bus, header scan flags, region choice
// and game compatibility quirks. Modules take it by wildcard import.

package cart_pkg;

	localparam int DL_ADDR_MAX_W = 25;

	// Host download bus with one 16-bit word per strobe
	typedef struct packed {
		logic                     download;
		logic                     wr;
		logic [DL_ADDR_MAX_W-1:0] addr;
		logic [15:0]              data;
		logic [7:0]               index;
	} dl_bus_s;

	// Any other index is a cartridge image
	localparam logic [7:0] CODE_INDEX = 8'hFF;

	////////////////////////////////////////
	// Header byte addresses
	localparam logic [DL_ADDR_MAX_W-1:0] HDR_REGION_ADDR0 = 25'h1F0;
	localparam logic [DL_ADDR_MAX_W-1:0] HDR_REGION_ADDR1 = 25'h1F2;
	localparam logic [DL_ADDR_MAX_W-1:0] HDR_END_ADDR     = 25'h200;
	localparam logic [DL_ADDR_MAX_W-1:0] ID_FIRST_ADDR    = 25'h182;
	localparam logic [DL_ADDR_MAX_W-1:0] ID_CHECK_ADDR    = 25'h18C;

	typedef struct packed {
		logic ready;
		logic j;
		logic u;
		logic e;
	} hdr_flags_s;

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_e;

	// Priority order 0 US>EU>JP, 1 EU>US>JP, 2 US>JP>EU, 3 JP>US>EU
	typedef struct packed {
		logic       auto_off;
		logic       use_header;
		logic [1:0] prio;
	} region_cfg_s;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic fifo;
		logic noram;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} quirk_s;

	// ROM write with word address and byte-swapped data
	typedef struct packed {
		logic [23:0] addr;
		logic [15:0] data;
	} rom_wr_s;

endpackage

// ==== source/cheat_pkg.sv ====
// Cheat record layout as assembled from code downloads.
// Each record arrives as eight 16-bit words, bottom word of
// each field first.

package cheat_pkg;

	// Fields kept in big endian order as sent by the host
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_s;

	////////////////////////////////////////
	// Byte offsets within one record
	localparam logic [3:0] CHEAT_FLAGS_LO   = 4'd0;
	localparam logic [3:0] CHEAT_FLAGS_HI   = 4'd2;
	localparam logic [3:0] CHEAT_ADDR_LO    = 4'd4;
	localparam logic [3:0] CHEAT_ADDR_HI    = 4'd6;
	localparam logic [3:0] CHEAT_CMP_LO     = 4'd8;
	localparam logic [3:0] CHEAT_CMP_HI     = 4'd10;
	localparam logic [3:0] CHEAT_REPL_LO    = 4'd12;
	// Replace top word closes the record
	localparam logic [3:0] CHEAT_LAST_OFFSET = 4'd14;

endpackage

// ==== source/region_scan.sv ====
// Scans the cartridge header for region letters while it downloads.
// Raises hdr.ready once the header has fully arrived, so region
// selection can act on a complete set of flags.

`timescale 1ns/100ps

module region_scan import cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       RESET,
	input  dl_bus_s    dl,
	input  logic       cart_dl,
	output hdr_flags_s hdr
);

	logic       cart_dl_q;
	logic [2:0] lo_flags;
	logic [2:0] hi_flags;
	logic       hdr_wr;

	// Classify one header byte as {j, u, e}
	function automatic logic [2:0] letter_flags(input logic [7:0] ch);
		logic [2:0] f;
		f = 3'b000;
		if (ch == "J")
			f = 3'b100;
		else if (ch == "U")
			f = 3'b010;
		else if (ch >= "0" && ch <= "Z")
			f = 3'b001;
		return f;
	endfunction

	assign hdr_wr   = cart_dl & dl.wr;
	assign lo_flags = letter_flags(dl.data[7:0]);
	assign hi_flags = letter_flags(dl.data[15:8]);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
			hdr       <= '0;
		end else begin
			cart_dl_q <= cart_dl;
			// New image starts with a clean header
			if (cart_dl & ~cart_dl_q)
				hdr <= '0;
			if (~cart_dl & cart_dl_q)
				hdr.ready <= 1'b0;
			if (hdr_wr) begin
				if (dl.addr == HDR_REGION_ADDR0)
					{hdr.j, hdr.u, hdr.e} <= {hdr.j, hdr.u, hdr.e} | lo_flags | hi_flags;
				else if (dl.addr == HDR_REGION_ADDR1)
					{hdr.j, hdr.u, hdr.e} <= {hdr.j, hdr.u, hdr.e} | lo_flags;
				if (dl.addr == HDR_END_ADDR)
					hdr.ready <= 1'b1;
			end
		end
	end

	// Header only completes inside a cartridge download
	ready_in_download: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(hdr.ready) |-> cart_dl);

endmodule

// ==== source/quirk_match.sv ====
// Captures the cartridge product code from the header and looks it
// up in the quirk table. At most one quirk flag is raised per image,
// and all flags clear when a new cartridge download starts.

`timescale 1ns/100ps

module quirk_match import cart_pkg::*; (
	input  logic    clk_sys,
	input  logic    RESET,
	input  dl_bus_s dl,
	input  logic    cart_dl,
	output quirk_s  quirks
);

	`include "quirk_ids.svh"

	logic [63:0] cart_id;
	logic        cart_dl_q;
	logic        id_wr;
	quirk_s      id_hit;

	function automatic logic id_match(input logic [63:0] id, input logic [63:0] pattern);
		logic ok;
		ok = 1'b1;
		for (int c = 0; c < 8; c++) begin
			if (pattern[c*8 +: 8] != "?" && pattern[c*8 +: 8] != id[c*8 +: 8])
				ok = 1'b0;
		end
		return ok;
	endfunction

	assign id_wr = cart_dl & dl.wr;

	////////////////////////////////////////
	// Product code capture of eight characters
	always_ff @(posedge clk_sys) begin
		if (id_wr) begin
			case (dl.addr)
				ID_FIRST_ADDR:        cart_id[63:56] <= dl.data[15:8];
				ID_FIRST_ADDR + 25'd2: cart_id[55:40] <= {dl.data[7:0], dl.data[15:8]};
				ID_FIRST_ADDR + 25'd4: cart_id[39:24] <= {dl.data[7:0], dl.data[15:8]};
				ID_FIRST_ADDR + 25'd6: cart_id[23:8]  <= {dl.data[7:0], dl.data[15:8]};
				ID_FIRST_ADDR + 25'd8: cart_id[7:0]   <= dl.data[7:0];
				default: ;
			endcase
		end
	end

	// First table entry wins
	always_comb begin
		id_hit = '0;
		for (int i = QUIRK_ID_COUNT - 1; i >= 0; i--) begin
			if (id_match(cart_id, QUIRK_IDS[i].code))
				id_hit = QUIRK_IDS[i].flag;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
			quirks    <= '0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_dl & ~cart_dl_q)
				quirks <= '0;
			if (id_wr && dl.addr == ID_CHECK_ADDR)
				quirks <= id_hit;
		end
	end

	single_quirk: assert property (@(posedge clk_sys) disable iff (RESET)
		$onehot0(quirks));

endmodule

// ==== source/region_select.sv ====
// Chooses the console region once the cartridge header is ready.
// The choice comes from the header letters under a configurable
// priority order, or from the file index of the download.

`timescale 1ns/100ps

module region_select import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  dl_bus_s     dl,
	input  hdr_flags_s  hdr,
	input  region_cfg_s region_cfg,
	output region_e     region_req,
	output logic        region_set
);

	logic ready_q;
	logic ready_rise;

	function automatic logic has_flag(input region_e r, input hdr_flags_s f);
		logic hit;
		case (r)
			JP:      hit = f.j;
			US:      hit = f.u;
			default: hit = f.e;
		endcase
		return hit;
	endfunction

	// Highest ranked region present or else the head of the order
	function automatic region_e pick_region(input logic [1:0] prio, input hdr_flags_s f);
		region_e order [3];
		region_e pick;
		case (prio)
			2'd0:    order = '{US, EU, JP};
			2'd1:    order = '{EU, US, JP};
			2'd2:    order = '{US, JP, EU};
			default: order = '{JP, US, EU};
		endcase
		pick = order[0];
		for (int i = 2; i >= 0; i--) begin
			if (has_flag(order[i], f))
				pick = order[i];
		end
		return pick;
	endfunction

	assign ready_rise = hdr.ready & ~ready_q;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_q    <= 1'b0;
			region_req <= JP;
			region_set <= 1'b0;
		end else begin
			ready_q <= hdr.ready;
			if (ready_rise && !region_cfg.auto_off) begin
				if (region_cfg.use_header) begin
					region_req <= pick_region(region_cfg.prio, hdr);
					region_set <= 1'b1;
				end else begin
					// Index zero means no region hint in the file
					region_req <= region_e'(dl.index[7:6]);
					region_set <= |dl.index;
				end
			end
			if (~hdr.ready & ready_q)
				region_set <= 1'b0;
		end
	end

endmodule

// ==== source/cheat_loader.sv ====
// Assembles cheat records from code download words.
// A record is complete on the replace top word; a write to address
// zero starts a new list and tells the core to drop old cheats.

`timescale 1ns/100ps

module cheat_loader import cart_pkg::*, cheat_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  dl_bus_s     dl,
	input  logic        code_dl,
	output cheat_code_s cheat,
	output logic        cheat_valid,
	output logic        cheat_clear
);

	logic code_wr;

	assign code_wr = code_dl & dl.wr;

	////////////////////////////////////////
	// Record fields with the bottom word first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.addr[3:0])
				CHEAT_FLAGS_LO:    cheat.flags[15:0]    <= dl.data;
				CHEAT_FLAGS_HI:    cheat.flags[31:16]   <= dl.data;
				CHEAT_ADDR_LO:     cheat.address[15:0]  <= dl.data;
				CHEAT_ADDR_HI:     cheat.address[31:16] <= dl.data;
				CHEAT_CMP_LO:      cheat.compare[15:0]  <= dl.data;
				CHEAT_CMP_HI:      cheat.compare[31:16] <= dl.data;
				CHEAT_REPL_LO:     cheat.replace[15:0]  <= dl.data;
				CHEAT_LAST_OFFSET: cheat.replace[31:16] <= dl.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_valid <= code_wr && dl.addr[3:0] == CHEAT_LAST_OFFSET;
			cheat_clear <= code_wr && dl.addr == '0;
		end
	end

endmodule

// ==== source/rom_write_bridge.sv ====
// Forwards cartridge words to ROM memory over a toggle request.
// The host is held off with dl_wait until the memory side copies
// the request level back, and the image size is kept at the end.

`timescale 1ns/100ps

module rom_write_bridge import cart_pkg::*; #(
	parameter int ADDR_W = 25
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  dl_bus_s           dl,
	input  logic              cart_dl,
	input  logic              rom_wr_ack,
	output rom_wr_s           rom_wr,
	output logic              rom_wr_req,
	output logic              dl_wait,
	output logic [ADDR_W-1:0] rom_size
);

	logic              cart_dl_q;
	logic              cart_wr;
	logic [ADDR_W-2:0] word_addr;

	assign cart_wr   = cart_dl & dl.wr;
	assign word_addr = dl.addr[ADDR_W-1:1];

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q  <= 1'b0;
			rom_wr_req <= 1'b0;
			dl_wait    <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_wr) begin
				rom_wr_req <= ~rom_wr_req;
				dl_wait    <= 1'b1;
			end else if (dl_wait && rom_wr_req == rom_wr_ack) begin
				dl_wait <= 1'b0;
			end
		end
	end

	// Memory is big endian and download words are little endian
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			rom_wr.addr <= word_addr;
			rom_wr.data <= {dl.data[7:0], dl.data[15:8]};
		end
		if (cart_dl_q & ~cart_dl)
			rom_size <= dl.addr[ADDR_W-1:0];
	end

	host_honours_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		cart_dl && dl_wait |-> !dl.wr);

endmodule

// ==== source/cart_loader_top.sv ====
// Cartridge loading front end of the console core.
// Splits the host download into cartridge and cheat traffic and
// feeds the ROM writer, header scanners, region choice and cheat
// assembly from the same bus.

`timescale 1ns/100ps

module cart_loader_top import cart_pkg::*, cheat_pkg::*; #(
	parameter int ADDR_W = 25
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  dl_bus_s           dl,
	input  region_cfg_s       region_cfg,
	input  logic              rom_wr_ack,
	output rom_wr_s           rom_wr,
	output logic              rom_wr_req,
	output logic              dl_wait,
	output logic [ADDR_W-1:0] rom_size,
	output quirk_s            quirks,
	output region_e           region_req,
	output logic              region_set,
	output cheat_code_s       cheat,
	output logic              cheat_valid,
	output logic              cheat_clear
);

	logic       cart_dl;
	logic       code_dl;
	hdr_flags_s hdr;

	// Download kind from the file index
	assign cart_dl = dl.download & (dl.index != CODE_INDEX);
	assign code_dl = dl.download & (dl.index == CODE_INDEX);

	////////////////////////////////////////
	// Cartridge path
	rom_write_bridge #(.ADDR_W(ADDR_W)) u_rom_write_bridge (
		.clk_sys, .RESET, .dl, .cart_dl, .rom_wr_ack,
		.rom_wr, .rom_wr_req, .dl_wait, .rom_size
	);

	region_scan u_region_scan (.clk_sys, .RESET, .dl, .cart_dl, .hdr);

	quirk_match u_quirk_match (.clk_sys, .RESET, .dl, .cart_dl, .quirks);

	region_select u_region_select (
		.clk_sys, .RESET, .dl, .hdr, .region_cfg, .region_req, .region_set
	);

	////////////////////////////////////////
	// Cheat path
	cheat_loader u_cheat_loader (
		.clk_sys, .RESET, .dl, .code_dl, .cheat, .cheat_valid, .cheat_clear
	);

endmodule

// ==== verification/cart_loader_tb.sv ====
// Testbench for the cartridge loading front end.
// A table of download steps is built first and then applied in a loop;
// a ROM model acknowledges each write after a random delay.
// Stops at the first mismatch.

`timescale 1ns/100ps

module cart_loader_tb import cart_pkg::*, cheat_pkg::*; ;

	localparam int WAIT_LIMIT = 40;

	localparam logic [3:0] OP_BEGIN  = 4'd0;
	localparam logic [3:0] OP_WRITE  = 4'd1;
	localparam logic [3:0] OP_END    = 4'd2;
	localparam logic [3:0] OP_REGION = 4'd3;
	localparam logic [3:0] OP_QUIRKS = 4'd4;
	localparam logic [3:0] OP_SIZE   = 4'd5;
	localparam logic [3:0] OP_CLEAR  = 4'd6;
	localparam logic [3:0] OP_CHEAT  = 4'd7;

	// One row of the stimulus table with its expected result
	typedef struct packed {
		logic [3:0]   op;
		logic [24:0]  addr;
		logic [15:0]  data;
		logic [7:0]   index;
		region_cfg_s  cfg;
		logic [127:0] exp;
	} step_s;

	logic        clk_sys = 1'b0;
	logic        RESET;
	dl_bus_s     dl;
	region_cfg_s region_cfg;
	logic        rom_wr_ack = 1'b0;
	rom_wr_s     rom_wr;
	logic        rom_wr_req;
	logic        dl_wait;
	logic [24:0] rom_size;
	quirk_s      quirks;
	region_e     region_req;
	logic        region_set;
	cheat_code_s cheat;
	logic        cheat_valid;
	logic        cheat_clear;

	step_s       steps [$];
	string       step_name [$];
	logic        cart_active = 1'b0;
	logic        exp_req = 1'b0;
	logic        seen_valid;
	logic        seen_clear;
	logic [31:0] lfsr = 32'hd975;
	logic [2:0]  new_delay = 3'd0;
	logic [2:0]  ack_delay = 3'd0;
	logic        ack_busy = 1'b0;

	cart_loader_top DUT (
		.clk_sys, .RESET, .dl, .region_cfg, .rom_wr_ack,
		.rom_wr, .rom_wr_req, .dl_wait, .rom_size, .quirks,
		.region_req, .region_set, .cheat, .cheat_valid, .cheat_clear
	);

	always #50 clk_sys = ~clk_sys;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	////////////////////////////////////////
	// ROM side copies the request back after 0 to 7 cycles
	always @(posedge clk_sys) begin
		if (RESET) begin
			ack_busy   <= 1'b0;
			rom_wr_ack <= 1'b0;
		end else if (ack_busy) begin
			if (ack_delay == 3'd0) begin
				rom_wr_ack <= rom_wr_req;
				ack_busy   <= 1'b0;
			end else begin
				ack_delay <= ack_delay - 3'd1;
			end
		end else if (rom_wr_req != rom_wr_ack) begin
			for (int b = 0; b < 3; b++) begin
				lfsr      = lfsr_step(lfsr);
				new_delay = {new_delay[1:0], lfsr[0]};
			end
			ack_delay <= new_delay;
			ack_busy  <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Failure reporting and typed compares
	task automatic stop_run();
		$display("Test failed");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_rom_wr(input string name, input rom_wr_s exp, input logic exp_tgl,
		input rom_wr_s act, input logic act_tgl);
		if (act !== exp || act_tgl !== exp_tgl) begin
			$display("FAILED %s: expected %h req %b, actual %h req %b",
				name, exp, exp_tgl, act, act_tgl);
			stop_run();
		end
	endtask

	task automatic check_region(input string name, input region_e exp, input logic exp_set,
		input region_e act, input logic act_set);
		if (act !== exp || act_set !== exp_set) begin
			$display("FAILED %s: expected %0d set %b, actual %0d set %b",
				name, exp, exp_set, act, act_set);
			stop_run();
		end
	endtask

	task automatic check_quirks(input string name, input quirk_s exp, input quirk_s act);
		if (act !== exp) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_cheat(input string name, input cheat_code_s exp,
		input cheat_code_s act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_size(input string name, input logic [24:0] exp,
		input logic [24:0] act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_pulse(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	////////////////////////////////////////
	// Stimulus table construction
	task automatic add_step(input string name, input logic [3:0] op, input logic [24:0] addr,
		input logic [15:0] data, input logic [7:0] index, input region_cfg_s cfg,
		input logic [127:0] exp);
		steps.push_back('{op: op, addr: addr, data: data, index: index, cfg: cfg, exp: exp});
		step_name.push_back(name);
	endtask

	// Plain image of 16 words ending before the header
	task automatic add_rom_run();
		add_step("rom begin", OP_BEGIN, '0, '0, 8'h01, '0, '0);
		for (int k = 0; k < 16; k++)
			add_step($sformatf("rom word %0d", k), OP_WRITE, 25'(2 * k),
				16'hA55A ^ (16'h0F1B * 16'(k)), 8'h01, '0, '0);
		add_step("rom end", OP_END, '0, '0, 8'h01, '0, '0);
		add_step("rom size", OP_SIZE, '0, '0, 8'h01, '0, 128'h1E);
	endtask

	// Header image with product code, region letters and end of header
	task automatic add_header_image(input string name, input region_cfg_s cfg,
		input logic [7:0] index, input logic [15:0] letters, input string code,
		input quirk_s exp_q, input region_e exp_r, input logic exp_set);
		add_step({name, " begin"}, OP_BEGIN, '0, '0, index, cfg, '0);
		add_step({name, " id0"}, OP_WRITE, 25'h182, {code[0], 8'h20}, index, cfg, '0);
		add_step({name, " id1"}, OP_WRITE, 25'h184, {code[2], code[1]}, index, cfg, '0);
		add_step({name, " id2"}, OP_WRITE, 25'h186, {code[4], code[3]}, index, cfg, '0);
		add_step({name, " id3"}, OP_WRITE, 25'h188, {code[6], code[5]}, index, cfg, '0);
		add_step({name, " id4"}, OP_WRITE, 25'h18A, {8'h20, code[7]}, index, cfg, '0);
		add_step({name, " id check"}, OP_WRITE, 25'h18C, 16'h2020, index, cfg, '0);
		add_step({name, " letters"}, OP_WRITE, 25'h1F0, letters, index, cfg, '0);
		add_step({name, " letters2"}, OP_WRITE, 25'h1F2, 16'h2020, index, cfg, '0);
		add_step({name, " hdr end"}, OP_WRITE, 25'h200, 16'h0000, index, cfg, '0);
		add_step({name, " region"}, OP_REGION, '0, '0, index, cfg, {exp_set, exp_r});
		add_step({name, " quirks"}, OP_QUIRKS, '0, '0, index, cfg, exp_q);
		add_step({name, " end"}, OP_END, '0, '0, index, cfg, '0);
		add_step({name, " size"}, OP_SIZE, '0, '0, index, cfg, 128'h200);
	endtask

	task automatic add_cheat_record();
		logic [15:0]  w [8];
		cheat_code_s  exp;
		w   = '{16'h0003, 16'h8000, 16'h1234, 16'h00FF, 16'hBEEF, 16'h0000, 16'hCAFE, 16'h0012};
		// Bottom word of each field first
		exp = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
		add_step("cheat begin", OP_BEGIN, '0, '0, CODE_INDEX, '0, '0);
		for (int k = 0; k < 8; k++) begin
			add_step($sformatf("cheat word %0d", k), OP_WRITE, 25'(2 * k), w[k],
				CODE_INDEX, '0, '0);
			if (k == 0)
				add_step("cheat clear", OP_CLEAR, '0, '0, CODE_INDEX, '0, '0);
		end
		add_step("cheat record", OP_CHEAT, '0, '0, CODE_INDEX, '0, exp);
		add_step("cheat end", OP_END, '0, '0, CODE_INDEX, '0, '0);
	endtask

	task automatic build_table();
		add_rom_run();
		add_header_image("ju prio0", 4'b0100, 8'h00, 16'h554A, "T-99999 ", '0, US, 1'b1);
		add_header_image("ju prio1", 4'b0101, 8'h00, 16'h554A, "T-99999 ", '0, US, 1'b1);
		add_header_image("ju prio2", 4'b0110, 8'h00, 16'h554A, "T-99999 ", '0, US, 1'b1);
		add_header_image("ju prio3", 4'b0111, 8'h00, 16'h554A, "T-99999 ", '0, JP, 1'b1);
		// Letters of the previous image must be gone
		add_header_image("blank prio1", 4'b0101, 8'h00, 16'h2020, "T-99999 ", '0, EU, 1'b1);
		add_header_image("index", 4'b0000, 8'h40, 16'h554A, "T-99999 ", '0, US, 1'b1);
		add_header_image("auto off", 4'b1000, 8'h40, 16'h554A, "T-99999 ", '0, US, 1'b0);
		add_header_image("quirk sram", 4'b0100, 8'h00, 16'h554A, "T-081276",
			quirk_s'{sram: 1'b1, default: 1'b0}, US, 1'b1);
		add_header_image("quirk svp", 4'b0100, 8'h00, 16'h554A, "MK-1229 ",
			quirk_s'{svp: 1'b1, default: 1'b0}, US, 1'b1);
		add_cheat_record();
	endtask

	////////////////////////////////////////
	// Bus driver
	task automatic write_word(input string name, input logic [24:0] addr,
		input logic [15:0] data);
		rom_wr_s exp_wr;
		int      waited;
		exp_wr.addr = addr[24:1];
		exp_wr.data = {data[7:0], data[15:8]};
		@(posedge clk_sys);
		dl.wr   <= 1'b1;
		dl.addr <= addr;
		dl.data <= data;
		@(posedge clk_sys);
		dl.wr <= 1'b0;
		@(negedge clk_sys);
		seen_valid = cheat_valid;
		seen_clear = cheat_clear;
		if (cart_active) begin
			exp_req = ~exp_req;
			check_pulse({name, " wait rise"}, 1'b1, dl_wait);
			check_rom_wr(name, exp_wr, exp_req, rom_wr, rom_wr_req);
		end
		waited = 0;
		while (dl_wait && waited < WAIT_LIMIT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (dl_wait) begin
			$display("Timeout: dl_wait did not fall after write %s", name);
			stop_run();
		end
		// Wait ends only after the acknowledge and the word stays held
		if (cart_active) begin
			check_pulse({name, " ack before wait fall"}, exp_req, rom_wr_ack);
			check_rom_wr({name, " held"}, exp_wr, exp_req, rom_wr, rom_wr_req);
		end
	endtask

	task automatic run_step(input string name, input step_s st);
		case (st.op)
			OP_BEGIN: begin
				@(posedge clk_sys);
				dl.download <= 1'b1;
				dl.index    <= st.index;
				dl.addr     <= '0;
				region_cfg  <= st.cfg;
				cart_active = (st.index != CODE_INDEX);
				@(posedge clk_sys);
			end
			OP_WRITE:
				write_word(name, st.addr, st.data);
			OP_END: begin
				@(posedge clk_sys);
				dl.download <= 1'b0;
				repeat (2) @(posedge clk_sys);
			end
			OP_REGION: begin
				@(negedge clk_sys);
				check_region(name, region_e'(st.exp[1:0]), st.exp[2], region_req, region_set);
			end
			OP_QUIRKS: begin
				@(negedge clk_sys);
				check_quirks(name, st.exp[7:0], quirks);
			end
			OP_SIZE: begin
				@(negedge clk_sys);
				check_size(name, st.exp[24:0], rom_size);
			end
			OP_CLEAR:
				check_pulse(name, 1'b1, seen_clear);
			OP_CHEAT: begin
				check_pulse({name, " valid"}, 1'b1, seen_valid);
				check_cheat(name, st.exp, cheat);
			end
			default: ;
		endcase
	endtask

	initial begin
		dl         = '0;
		region_cfg = '0;
		RESET      = 1'b1;
		build_table();
		repeat (4) @(posedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		check_pulse("reset dl_wait", 1'b0, dl_wait);
		check_pulse("reset rom_wr_req", 1'b0, rom_wr_req);
		check_pulse("reset region_set", 1'b0, region_set);
		check_pulse("reset cheat_valid", 1'b0, cheat_valid);
		check_pulse("reset cheat_clear", 1'b0, cheat_clear);
		check_quirks("reset quirks", '0, quirks);
		for (int i = 0; i < steps.size(); i++)
			run_step(step_name[i], steps[i]);
		$display("Test passed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+include
source/cart_pkg.sv
source/cheat_pkg.sv
source/region_scan.sv
source/quirk_match.sv
source/region_select.sv
source/cheat_loader.sv
source/rom_write_bridge.sv
source/cart_loader_top.sv
verification/cart_loader_tb.sv

// ==== Bender.yml ====
package:
  name: cart_loader

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/cart_pkg.sv
      - source/cheat_pkg.sv
      - source/region_scan.sv
      - source/quirk_match.sv
      - source/region_select.sv
      - source/cheat_loader.sv
      - source/rom_write_bridge.sv
      - source/cart_loader_top.sv
  - target: simulation
    files:
      - verification/cart_loader_tb.sv
